// ==== disp_cfg_pkg.sv ====
package disp_cfg_pkg;

  // memory bus widths
  localparam int ADDR_W = 16;
  // data word, also used for thread channels
  localparam int DATA_W = 16;

  // ext_cpu_index encoding
  localparam int CPU_IDX_W = 8;
  // set for an active cpu, number sits in the low bits
  localparam int CPU_ACTIVE_BIT = 7;
  // offer to whichever non-active cpu answers
  localparam logic [CPU_IDX_W-1:0] CPU_NONACTIVE_IDX = 8'h7F;

  // top level parameter defaults
  localparam int DEF_CPU_QUANTITY = 4;
  localparam int DEF_PROC_QUANTITY = 8;

endpackage

// ==== disp_msg_pkg.sv ====
package disp_msg_pkg;

  // messages on cpu_msg_in / cpu_msg_out
  typedef enum logic [3:0] {
    NONE      = 4'd0,
    START     = 4'd1,
    END       = 4'd2,
    FORK_THRD = 4'd3,
    STOP_THRD = 4'd4,
    FORK_DONE = 4'd5,
    STOP_DONE = 4'd6
  } cpu_msg_t;

  // controller to thread table commands
  typedef enum logic [1:0] {
    NULL = 2'd0,
    RUN  = 2'd1,
    STOP = 2'd2,
    NEXT = 2'd3
  } thread_cmd_t;

  // controller fsm
  typedef enum logic [1:0] {
    CPU_LOOP = 2'd0,
    CPU_CMD  = 2'd1,
    MEM_WORK = 2'd2
  } ctl_state_t;

endpackage

// ==== thread_cmd_if.sv ====
`timescale 1ns/10ps

interface thread_cmd_if (
  input logic clk
);

  // request side, from the controller
  disp_msg_pkg::thread_cmd_t           cmd;
  logic [disp_cfg_pkg::ADDR_W-1:0]     addr;
  logic [disp_cfg_pkg::DATA_W-1:0]     chan;

  // table side
  logic                                done;
  logic [disp_cfg_pkg::ADDR_W-1:0]     next_proc;
  logic                                full;

  modport ctl (output cmd, addr, chan, input done, next_proc, full);
  modport tbl (input cmd, addr, chan, output done, next_proc, full);

  // fork and stop always get their reply one cycle later
  a_cmd_done: assert property (@(posedge clk)
    (cmd == disp_msg_pkg::RUN || cmd == disp_msg_pkg::STOP) |=> done);

endinterface

// ==== dispatch_ctl.sv ====
`timescale 1ns/10ps

module dispatch_ctl #(
  parameter int CPU_QUANTITY = 4
) (
  input  logic                                 clk,
  input  logic                                 ext_rst_e,
  input  logic [disp_cfg_pkg::ADDR_W-1:0]      addr_in,
  input  logic [disp_cfg_pkg::DATA_W-1:0]      data_in,
  input  logic                                 read_q,
  input  logic                                 write_q,
  input  logic                                 ext_cpu_e,
  input  disp_msg_pkg::cpu_msg_t               cpu_msg_in,
  input  logic                                 mem_busy,
  input  logic                                 mem_finish,
  output logic                                 ext_cpu_q,
  output logic [disp_cfg_pkg::CPU_IDX_W-1:0]   ext_cpu_index,
  output logic [disp_cfg_pkg::ADDR_W-1:0]      addr_out,
  output logic                                 bus_busy,
  output logic                                 start_rd,
  output logic                                 start_wr,
  output logic [disp_cfg_pkg::ADDR_W-1:0]      req_addr,
  output logic [disp_cfg_pkg::DATA_W-1:0]      req_wdata,
  thread_cmd_if.ctl                            tif
);

  localparam int IDX_W = disp_cfg_pkg::CPU_IDX_W;
  // counts run 0..CPU_QUANTITY
  localparam int CNT_W = $clog2(CPU_QUANTITY + 1);

  disp_msg_pkg::ctl_state_t  state;
  disp_msg_pkg::thread_cmd_t thr_cmd;

  logic [CNT_W-1:0] act_cnt;
  logic [CNT_W-1:0] nact_cnt;
  logic [CNT_W-1:0] cpu_num;
  logic [CNT_W-1:0] next_num;
  // last offer went to the non-active group
  logic             na_offered;
  logic             offer_na;
  logic             rw_go;
  logic [IDX_W-1:0] act_idx;

  // non-active offer alternates with active ones, or repeats with none active
  assign offer_na = (nact_cnt != '0) && (!na_offered || act_cnt == '0);
  // round robin over active cpus
  assign next_num = (cpu_num >= act_cnt - 1'b1) ? '0 : cpu_num + 1'b1;
  assign act_idx  = IDX_W'(next_num) | (IDX_W'(1) << disp_cfg_pkg::CPU_ACTIVE_BIT);

  // memory access wins over every message
  assign rw_go     = (state == disp_msg_pkg::CPU_CMD) && (read_q || write_q) && !mem_busy;
  assign start_rd  = rw_go && read_q;
  assign start_wr  = rw_go && write_q;
  assign req_addr  = addr_in;
  assign req_wdata = data_in;
  assign bus_busy  = (state == disp_msg_pkg::MEM_WORK);

  // thread command is valid only in the decode cycle
  always_comb begin
    thr_cmd = disp_msg_pkg::NULL;
    if (state == disp_msg_pkg::CPU_CMD && !read_q && !write_q) begin
      if (ext_cpu_e) begin
        // new cpu picks up the next thread
        if (cpu_msg_in == disp_msg_pkg::START && nact_cnt != '0) begin
          thr_cmd = disp_msg_pkg::NEXT;
        end
      end else if (cpu_msg_in == disp_msg_pkg::FORK_THRD && !tif.full) begin
        thr_cmd = disp_msg_pkg::RUN;
      end else if (cpu_msg_in == disp_msg_pkg::STOP_THRD) begin
        thr_cmd = disp_msg_pkg::STOP;
      end
    end
  end

  assign tif.cmd  = thr_cmd;
  assign tif.addr = addr_in;
  assign tif.chan = data_in;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state         <= disp_msg_pkg::CPU_LOOP;
      act_cnt       <= '0;
      nact_cnt      <= CNT_W'(CPU_QUANTITY);
      cpu_num       <= '0;
      na_offered    <= 1'b0;
      ext_cpu_q     <= 1'b0;
      ext_cpu_index <= '0;
      addr_out      <= '0;
    end else begin
      // offer pulse and its address last one cycle
      ext_cpu_q <= 1'b0;
      addr_out  <= '0;
      case (state)
        disp_msg_pkg::CPU_LOOP: begin
          ext_cpu_q <= 1'b1;
          addr_out  <= tif.next_proc;
          if (offer_na) begin
            ext_cpu_index <= disp_cfg_pkg::CPU_NONACTIVE_IDX;
            na_offered    <= 1'b1;
          end else begin
            ext_cpu_index <= act_idx;
            cpu_num       <= next_num;
            na_offered    <= 1'b0;
          end
          state <= disp_msg_pkg::CPU_CMD;
        end
        disp_msg_pkg::CPU_CMD: begin
          if (rw_go) begin
            state <= disp_msg_pkg::MEM_WORK;
          end else if (ext_cpu_e) begin
            // start/end move one cpu between the groups
            if (cpu_msg_in == disp_msg_pkg::START && nact_cnt != '0) begin
              nact_cnt <= nact_cnt - 1'b1;
              act_cnt  <= act_cnt + 1'b1;
            end else if (cpu_msg_in == disp_msg_pkg::END && act_cnt != '0) begin
              act_cnt  <= act_cnt - 1'b1;
              nact_cnt <= nact_cnt + 1'b1;
            end
            state <= disp_msg_pkg::CPU_LOOP;
          end else if (thr_cmd != disp_msg_pkg::NULL) begin
            state <= disp_msg_pkg::CPU_LOOP;
          end
        end
        disp_msg_pkg::MEM_WORK: begin
          if (mem_finish) begin
            state <= disp_msg_pkg::CPU_LOOP;
          end
        end
        default: state <= disp_msg_pkg::CPU_LOOP;
      endcase
    end
  end

  a_act_cnt_max: assert property (@(posedge clk) disable iff (ext_rst_e)
    act_cnt <= CNT_W'(CPU_QUANTITY));

  a_start_onehot: assert property (@(posedge clk) disable iff (ext_rst_e)
    !(start_rd && start_wr));

endmodule

// ==== mem_forwarder.sv ====
`timescale 1ns/10ps

module mem_forwarder (
  input  logic                              clk,
  input  logic                              ext_rst_e,
  input  logic                              start_rd,
  input  logic                              start_wr,
  input  logic [disp_cfg_pkg::ADDR_W-1:0]   req_addr,
  input  logic [disp_cfg_pkg::DATA_W-1:0]   req_wdata,
  input  logic                              ext_read_dn,
  input  logic                              ext_write_dn,
  input  logic [disp_cfg_pkg::ADDR_W-1:0]   ext_mem_addr_in,
  input  logic [disp_cfg_pkg::DATA_W-1:0]   ext_mem_data_in,
  output logic                              mem_busy,
  output logic                              mem_finish,
  output logic                              ext_read_q,
  output logic                              ext_write_q,
  output logic [disp_cfg_pkg::ADDR_W-1:0]   ext_mem_addr_out,
  output logic [disp_cfg_pkg::DATA_W-1:0]   ext_mem_data_out,
  output logic                              read_dn,
  output logic                              write_dn,
  output logic [disp_cfg_pkg::ADDR_W-1:0]   done_addr,
  output logic [disp_cfg_pkg::DATA_W-1:0]   rd_data
);

  // one outstanding access at a time
  logic                            rd_pend;
  logic                            wr_pend;
  logic [disp_cfg_pkg::ADDR_W-1:0] addr_q;
  logic [disp_cfg_pkg::DATA_W-1:0] wdata_q;
  logic                            fin_rd;
  logic                            fin_wr;

  assign fin_rd     = rd_pend && ext_read_dn;
  assign fin_wr     = wr_pend && ext_write_dn;
  assign mem_finish = fin_rd || fin_wr;
  assign mem_busy   = rd_pend || wr_pend;

  // request levels held until the memory answers
  assign ext_read_q       = rd_pend;
  assign ext_write_q      = wr_pend;
  // bus reads zero when idle
  assign ext_mem_addr_out = mem_busy ? addr_q : '0;
  assign ext_mem_data_out = wr_pend ? wdata_q : '0;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      rd_pend  <= 1'b0;
      wr_pend  <= 1'b0;
      read_dn  <= 1'b0;
      write_dn <= 1'b0;
      rd_data  <= '0;
    end else begin
      if (start_rd) begin
        rd_pend <= 1'b1;
      end else if (fin_rd) begin
        rd_pend <= 1'b0;
      end
      if (start_wr) begin
        wr_pend <= 1'b1;
      end else if (fin_wr) begin
        wr_pend <= 1'b0;
      end
      // done pulses one cycle behind the memory
      read_dn  <= fin_rd;
      write_dn <= fin_wr;
      // read data only shown with read_dn
      rd_data  <= fin_rd ? ext_mem_data_in : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_rd || start_wr) begin
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
    // address echoed back by the memory
    if (mem_finish) begin
      done_addr <= ext_mem_addr_in;
    end
  end

  a_rw_excl: assert property (@(posedge clk) disable iff (ext_rst_e)
    !(ext_read_q && ext_write_q));

  // controller must wait for the previous access
  a_no_start_busy: assert property (@(posedge clk) disable iff (ext_rst_e)
    (start_rd || start_wr) |-> !mem_busy);

endmodule

// ==== thread_table.sv ====
`timescale 1ns/10ps

module thread_table #(
  parameter int PROC_QUANTITY = 8
) (
  input  logic                             clk,
  input  logic                             ext_rst_e,
  output disp_msg_pkg::cpu_msg_t           cpu_msg_out,
  output logic [disp_cfg_pkg::DATA_W-1:0]  chan_out,
  thread_cmd_if.tbl                        tif
);

  localparam int PTR_W = (PROC_QUANTITY > 1) ? $clog2(PROC_QUANTITY) : 1;

  logic [PROC_QUANTITY-1:0]        slot_vld;
  logic [disp_cfg_pkg::ADDR_W-1:0] slot_addr [PROC_QUANTITY];
  logic [disp_cfg_pkg::DATA_W-1:0] slot_chan [PROC_QUANTITY];
  logic [PTR_W-1:0]                rr_ptr;
  logic [PTR_W-1:0]                rr_next;
  logic [PTR_W-1:0]                free_idx;
  logic [PTR_W-1:0]                hit_idx;
  logic                            hit;

  // lowest free slot, and the slot holding tif.addr
  always_comb begin
    free_idx = '0;
    hit_idx  = '0;
    hit      = 1'b0;
    for (int i = PROC_QUANTITY - 1; i >= 0; i--) begin
      if (!slot_vld[i]) begin
        free_idx = PTR_W'(i);
      end
      if (slot_vld[i] && slot_addr[i] == tif.addr) begin
        hit     = 1'b1;
        hit_idx = PTR_W'(i);
      end
    end
  end

  // first valid slot after the pointer, wrapping; nearest one wins
  always_comb begin : rr_scan
    int j;
    rr_next = rr_ptr;
    for (int k = PROC_QUANTITY; k >= 1; k--) begin
      j = (int'(rr_ptr) + k) % PROC_QUANTITY;
      if (slot_vld[j]) begin
        rr_next = PTR_W'(j);
      end
    end
  end

  // empty slot under the pointer gives address 0
  assign tif.next_proc = slot_vld[rr_ptr] ? slot_addr[rr_ptr] : '0;
  assign tif.full      = &slot_vld;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      slot_vld    <= '0;
      rr_ptr      <= '0;
      tif.done    <= 1'b0;
      cpu_msg_out <= disp_msg_pkg::NONE;
    end else begin
      // reply lasts one cycle
      tif.done    <= 1'b0;
      cpu_msg_out <= disp_msg_pkg::NONE;
      case (tif.cmd)
        disp_msg_pkg::RUN: begin
          slot_vld[free_idx] <= 1'b1;
          tif.done           <= 1'b1;
          cpu_msg_out        <= disp_msg_pkg::FORK_DONE;
        end
        disp_msg_pkg::STOP: begin
          // unknown address still gets its reply
          if (hit) begin
            slot_vld[hit_idx] <= 1'b0;
          end
          tif.done    <= 1'b1;
          cpu_msg_out <= disp_msg_pkg::STOP_DONE;
        end
        disp_msg_pkg::NEXT: rr_ptr <= rr_next;
        default: ;
      endcase
    end
  end

  // slot contents and reply channel
  always_ff @(posedge clk) begin
    if (tif.cmd == disp_msg_pkg::RUN) begin
      slot_addr[free_idx] <= tif.addr;
      slot_chan[free_idx] <= tif.chan;
      chan_out            <= tif.chan;
    end else if (tif.cmd == disp_msg_pkg::STOP) begin
      chan_out <= hit ? slot_chan[hit_idx] : tif.chan;
    end
  end

  a_no_run_full: assert property (@(posedge clk) disable iff (ext_rst_e)
    (tif.cmd == disp_msg_pkg::RUN) |-> !tif.full);

endmodule

// ==== cpu_dispatcher.sv ====
`timescale 1ns/10ps

module cpu_dispatcher #(
  parameter int CPU_QUANTITY  = disp_cfg_pkg::DEF_CPU_QUANTITY,
  parameter int PROC_QUANTITY = disp_cfg_pkg::DEF_PROC_QUANTITY
) (
  input  logic                                clk,
  input  logic                                ext_rst_e,
  input  logic [disp_cfg_pkg::ADDR_W-1:0]     addr_in,
  output logic [disp_cfg_pkg::ADDR_W-1:0]     addr_out,
  input  logic [disp_cfg_pkg::DATA_W-1:0]     data_in,
  output logic [disp_cfg_pkg::DATA_W-1:0]     data_out,
  input  logic                                read_q,
  input  logic                                write_q,
  output logic                                read_dn,
  output logic                                write_dn,
  output logic                                bus_busy,
  output logic [disp_cfg_pkg::CPU_IDX_W-1:0]  ext_cpu_index,
  output logic                                ext_cpu_q,
  input  logic                                ext_cpu_e,
  input  disp_msg_pkg::cpu_msg_t              cpu_msg_in,
  output disp_msg_pkg::cpu_msg_t              cpu_msg_out,
  input  logic [disp_cfg_pkg::ADDR_W-1:0]     ext_mem_addr_in,
  output logic [disp_cfg_pkg::ADDR_W-1:0]     ext_mem_addr_out,
  input  logic [disp_cfg_pkg::DATA_W-1:0]     ext_mem_data_in,
  output logic [disp_cfg_pkg::DATA_W-1:0]     ext_mem_data_out,
  output logic                                ext_read_q,
  output logic                                ext_write_q,
  input  logic                                ext_read_dn,
  input  logic                                ext_write_dn
);

  logic                            start_rd;
  logic                            start_wr;
  logic                            mem_busy;
  logic                            mem_finish;
  logic [disp_cfg_pkg::ADDR_W-1:0] req_addr;
  logic [disp_cfg_pkg::DATA_W-1:0] req_wdata;
  logic [disp_cfg_pkg::ADDR_W-1:0] offer_addr;
  logic [disp_cfg_pkg::ADDR_W-1:0] done_addr;
  logic [disp_cfg_pkg::DATA_W-1:0] rd_data;
  logic [disp_cfg_pkg::DATA_W-1:0] chan_out;

  thread_cmd_if tif0 (.clk(clk));

  dispatch_ctl #(.CPU_QUANTITY(CPU_QUANTITY)) ctl0 (
    .clk(clk), .ext_rst_e(ext_rst_e),
    .addr_in(addr_in), .data_in(data_in),
    .read_q(read_q), .write_q(write_q),
    .ext_cpu_e(ext_cpu_e), .cpu_msg_in(cpu_msg_in),
    .mem_busy(mem_busy), .mem_finish(mem_finish),
    .ext_cpu_q(ext_cpu_q), .ext_cpu_index(ext_cpu_index),
    .addr_out(offer_addr), .bus_busy(bus_busy),
    .start_rd(start_rd), .start_wr(start_wr),
    .req_addr(req_addr), .req_wdata(req_wdata),
    .tif(tif0.ctl)
  );

  mem_forwarder fwd0 (
    .clk(clk), .ext_rst_e(ext_rst_e),
    .start_rd(start_rd), .start_wr(start_wr),
    .req_addr(req_addr), .req_wdata(req_wdata),
    .ext_read_dn(ext_read_dn), .ext_write_dn(ext_write_dn),
    .ext_mem_addr_in(ext_mem_addr_in), .ext_mem_data_in(ext_mem_data_in),
    .mem_busy(mem_busy), .mem_finish(mem_finish),
    .ext_read_q(ext_read_q), .ext_write_q(ext_write_q),
    .ext_mem_addr_out(ext_mem_addr_out), .ext_mem_data_out(ext_mem_data_out),
    .read_dn(read_dn), .write_dn(write_dn),
    .done_addr(done_addr), .rd_data(rd_data)
  );

  thread_table #(.PROC_QUANTITY(PROC_QUANTITY)) tbl0 (
    .clk(clk), .ext_rst_e(ext_rst_e),
    .cpu_msg_out(cpu_msg_out), .chan_out(chan_out),
    .tif(tif0.tbl)
  );

  // completed access address, otherwise the thread offer
  assign addr_out = (read_dn || write_dn) ? done_addr : offer_addr;
  // fork/stop replies carry the channel
  assign data_out = (cpu_msg_out != disp_msg_pkg::NONE) ? chan_out : rd_data;

endmodule

// ==== tb_dispatch_tests.svh ====
`ifndef TB_DISPATCH_TESTS_SVH
`define TB_DISPATCH_TESTS_SVH

// cpu side quiet
task automatic idle_inputs();
  addr_in    = '0;
  data_in    = '0;
  read_q     = 1'b0;
  write_q    = 1'b0;
  ext_cpu_e  = 1'b0;
  cpu_msg_in = disp_msg_pkg::NONE;
endtask

// called on a falling edge, returns on the edge that shows the offer
task automatic wait_offer(output logic [IDX_W-1:0] idx, output logic [ADDR_W-1:0] a);
  while (!ext_cpu_q) begin
    @(negedge clk);
  end
  idx = ext_cpu_index;
  a   = addr_out;
endtask

task automatic expect_offer(input logic [IDX_W-1:0] idx, input logic [ADDR_W-1:0] a);
  logic [IDX_W-1:0]  got_idx;
  logic [ADDR_W-1:0] got_a;
  wait_offer(got_idx, got_a);
  compare_idx("ext_cpu_index", got_idx, idx);
  compare_addr("addr_out", got_a, a);
endtask

// offer due exactly one cycle after the last response
task automatic expect_offer_now(input logic [IDX_W-1:0] idx, input logic [ADDR_W-1:0] a);
  @(negedge clk);
  compare_bit("ext_cpu_q", ext_cpu_q, 1'b1);
  compare_idx("ext_cpu_index", ext_cpu_index, idx);
  compare_addr("addr_out", addr_out, a);
endtask

// answer the offer shown now, one cycle of drive
task automatic send_msg(input logic cpu_e, input disp_msg_pkg::cpu_msg_t msg,
                        input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
  ext_cpu_e  = cpu_e;
  cpu_msg_in = msg;
  addr_in    = a;
  data_in    = d;
  @(negedge clk);
  idle_inputs();
  compare_bit("ext_cpu_q", ext_cpu_q, 1'b0);
endtask

task automatic pass_offer();
  send_msg(1'b1, disp_msg_pkg::NONE, '0, '0);
endtask

task automatic mem_access(input logic is_write, input logic [ADDR_W-1:0] a,
                          input logic [DATA_W-1:0] wd, input logic [DATA_W-1:0] exp_rd);
  logic [IDX_W-1:0]  idx;
  logic [ADDR_W-1:0] offer_a;
  wait_offer(idx, offer_a);
  read_q  = !is_write;
  write_q = is_write;
  addr_in = a;
  data_in = wd;
  @(negedge clk);
  idle_inputs();
  // request level and bus held until done comes back
  while (!(read_dn || write_dn)) begin
    compare_bit(is_write ? "ext_write_q" : "ext_read_q",
                is_write ? ext_write_q : ext_read_q, 1'b1);
    compare_bit("bus_busy", bus_busy, 1'b1);
    compare_addr("ext_mem_addr_out", ext_mem_addr_out, a);
    if (is_write) begin
      compare_data("ext_mem_data_out", ext_mem_data_out, wd);
    end
    @(negedge clk);
  end
  compare_bit(is_write ? "write_dn" : "read_dn", is_write ? write_dn : read_dn, 1'b1);
  compare_bit("memory done one edge earlier", is_write ? edge_wr_dn : edge_rd_dn, 1'b1);
  compare_addr("addr_out", addr_out, a);
  if (!is_write) begin
    compare_data("data_out", data_out, exp_rd);
  end
  compare_bit("bus_busy", bus_busy, 1'b0);
  @(negedge clk);
  compare_bit("read_dn", read_dn, 1'b0);
  compare_bit("write_dn", write_dn, 1'b0);
endtask

// outputs under reset, then the first offer
task automatic test_reset();
  compare_bit("ext_cpu_q", ext_cpu_q, 1'b0);
  compare_bit("ext_read_q", ext_read_q, 1'b0);
  compare_bit("ext_write_q", ext_write_q, 1'b0);
  compare_bit("read_dn", read_dn, 1'b0);
  compare_bit("write_dn", write_dn, 1'b0);
  compare_bit("bus_busy", bus_busy, 1'b0);
  compare_msg("cpu_msg_out", cpu_msg_out, disp_msg_pkg::NONE);
  compare_data("data_out", data_out, '0);
  compare_addr("addr_out", addr_out, '0);
  compare_addr("ext_mem_addr_out", ext_mem_addr_out, '0);
  ext_rst_e = 1'b0;
  expect_offer(NA_IDX, '0);
  pass_offer();
endtask

// one start gives alternating offers, end goes back to non-active only
task automatic test_start_end();
  expect_offer(NA_IDX, '0);
  send_msg(1'b1, disp_msg_pkg::START, '0, '0);
  expect_offer_now(ACT0_IDX, '0);
  pass_offer();
  expect_offer_now(NA_IDX, '0);
  pass_offer();
  expect_offer_now(ACT0_IDX, '0);
  pass_offer();
  expect_offer_now(NA_IDX, '0);
  send_msg(1'b1, disp_msg_pkg::END, '0, '0);
  expect_offer_now(NA_IDX, '0);
  pass_offer();
  expect_offer_now(NA_IDX, '0);
  pass_offer();
endtask

task automatic test_fork(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] c);
  expect_offer(NA_IDX, '0);
  send_msg(1'b0, disp_msg_pkg::FORK_THRD, a, c);
  compare_msg("cpu_msg_out", cpu_msg_out, disp_msg_pkg::FORK_DONE);
  compare_data("data_out", data_out, c);
  // only thread in the table, pointer still on slot 0
  expect_offer_now(NA_IDX, a);
  compare_msg("cpu_msg_out", cpu_msg_out, disp_msg_pkg::NONE);
  // start hands the next thread to the new cpu
  send_msg(1'b1, disp_msg_pkg::START, '0, '0);
  expect_offer_now(ACT0_IDX, a);
  pass_offer();
  expect_offer_now(NA_IDX, a);
  pass_offer();
endtask

task automatic test_memory();
  mem_access(1'b0, 16'h0040, '0, fill_word(16'h0040));
  mem_access(1'b1, 16'h0123, 16'hBEEF, '0);
  mem_access(1'b1, 16'h8ACE, 16'h1357, '0);
  mem_access(1'b0, 16'h0123, '0, 16'hBEEF);
  mem_access(1'b0, 16'h8ACE, '0, 16'h1357);
endtask

task automatic test_stop(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] c);
  logic [IDX_W-1:0]  idx;
  logic [ADDR_W-1:0] offer_a;
  wait_offer(idx, offer_a);
  compare_addr("addr_out", offer_a, a);
  send_msg(1'b0, disp_msg_pkg::STOP_THRD, a, '0);
  compare_msg("cpu_msg_out", cpu_msg_out, disp_msg_pkg::STOP_DONE);
  // stored channel comes back with the reply
  compare_data("data_out", data_out, c);
  // table empty again
  wait_offer(idx, offer_a);
  compare_addr("addr_out", offer_a, '0);
  pass_offer();
  wait_offer(idx, offer_a);
  compare_addr("addr_out", offer_a, '0);
  pass_offer();
endtask

`endif

// ==== tb_cpu_dispatcher.sv ====
`timescale 1ns/10ps

module tb_cpu_dispatcher;

  localparam int ADDR_W = disp_cfg_pkg::ADDR_W;
  localparam int DATA_W = disp_cfg_pkg::DATA_W;
  localparam int IDX_W  = disp_cfg_pkg::CPU_IDX_W;
  // tests need a few hundred cycles, this leaves ample margin
  localparam int TIMEOUT_CYCLES = 2000;
  localparam logic [IDX_W-1:0] NA_IDX   = disp_cfg_pkg::CPU_NONACTIVE_IDX;
  // active cpu 0
  localparam logic [IDX_W-1:0] ACT0_IDX = 1 << disp_cfg_pkg::CPU_ACTIVE_BIT;

  logic                   clk;
  logic                   ext_rst_e;
  logic [ADDR_W-1:0]      addr_in;
  logic [ADDR_W-1:0]      addr_out;
  logic [DATA_W-1:0]      data_in;
  logic [DATA_W-1:0]      data_out;
  logic                   read_q;
  logic                   write_q;
  logic                   read_dn;
  logic                   write_dn;
  logic                   bus_busy;
  logic [IDX_W-1:0]       ext_cpu_index;
  logic                   ext_cpu_q;
  logic                   ext_cpu_e;
  disp_msg_pkg::cpu_msg_t cpu_msg_in;
  disp_msg_pkg::cpu_msg_t cpu_msg_out;
  logic [ADDR_W-1:0]      ext_mem_addr_in;
  logic [ADDR_W-1:0]      ext_mem_addr_out;
  logic [DATA_W-1:0]      ext_mem_data_in;
  logic [DATA_W-1:0]      ext_mem_data_out;
  logic                   ext_read_q;
  logic                   ext_write_q;
  logic                   ext_read_dn;
  logic                   ext_write_dn;

  // memory done levels as the dut saw them on the last rising edge
  logic                   edge_rd_dn;
  logic                   edge_wr_dn;
  int unsigned            cycle_cnt = 0;
  // lfsr seed
  logic [15:0]            lfsr_state = 16'd38;
  logic [DATA_W-1:0]      mem_words [0:(1 << ADDR_W) - 1];

  cpu_dispatcher #(.CPU_QUANTITY(4), .PROC_QUANTITY(8)) dut0 (
    .clk(clk), .ext_rst_e(ext_rst_e),
    .addr_in(addr_in), .addr_out(addr_out),
    .data_in(data_in), .data_out(data_out),
    .read_q(read_q), .write_q(write_q),
    .read_dn(read_dn), .write_dn(write_dn), .bus_busy(bus_busy),
    .ext_cpu_index(ext_cpu_index), .ext_cpu_q(ext_cpu_q), .ext_cpu_e(ext_cpu_e),
    .cpu_msg_in(cpu_msg_in), .cpu_msg_out(cpu_msg_out),
    .ext_mem_addr_in(ext_mem_addr_in), .ext_mem_addr_out(ext_mem_addr_out),
    .ext_mem_data_in(ext_mem_data_in), .ext_mem_data_out(ext_mem_data_out),
    .ext_read_q(ext_read_q), .ext_write_q(ext_write_q),
    .ext_read_dn(ext_read_dn), .ext_write_dn(ext_write_dn)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic compare_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_msg(input string name, input disp_msg_pkg::cpu_msg_t got,
                             input disp_msg_pkg::cpu_msg_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_idx(input string name, input logic [IDX_W-1:0] got,
                             input logic [IDX_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // power-up memory contents, every address bit matters
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return ~a ^ {a[7:0], a[15:8]} ^ 16'h5A3C;
  endfunction

  `include "tb_dispatch_tests.svh"

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      fail_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  always @(posedge clk) begin
    edge_rd_dn <= ext_read_dn;
    edge_wr_dn <= ext_write_dn;
  end

  // external memory, answers 1 to 4 cycles after a request shows up
  initial begin : mem_model
    logic [1:0]        dly_bits;
    logic              wr;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] wd;
    ext_read_dn     = 1'b0;
    ext_write_dn    = 1'b0;
    ext_mem_addr_in = '0;
    ext_mem_data_in = '0;
    for (int i = 0; i < (1 << ADDR_W); i++) begin
      mem_words[i] = fill_word(i[ADDR_W-1:0]);
    end
    forever begin
      @(negedge clk);
      if (!ext_rst_e && (ext_read_q || ext_write_q)) begin
        wr = ext_write_q;
        a  = ext_mem_addr_out;
        wd = ext_mem_data_out;
        // one lfsr step per delay bit
        lfsr_state  = lfsr_step(lfsr_state);
        dly_bits[0] = lfsr_state[0];
        lfsr_state  = lfsr_step(lfsr_state);
        dly_bits[1] = lfsr_state[0];
        repeat (int'(dly_bits) + 1) @(negedge clk);
        ext_mem_addr_in = a;
        if (wr) begin
          mem_words[a] = wd;
          ext_write_dn = 1'b1;
        end else begin
          ext_mem_data_in = mem_words[a];
          ext_read_dn     = 1'b1;
        end
        @(negedge clk);
        ext_read_dn     = 1'b0;
        ext_write_dn    = 1'b0;
        ext_mem_addr_in = '0;
        ext_mem_data_in = '0;
      end
    end
  end

  initial begin
    ext_rst_e = 1'b1;
    idle_inputs();
    repeat (16) @(negedge clk);
    test_reset();
    test_start_end();
    test_fork(16'h1234, 16'h00C5);
    test_memory();
    test_stop(16'h1234, 16'h00C5);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
disp_cfg_pkg.sv
disp_msg_pkg.sv
thread_cmd_if.sv
dispatch_ctl.sv
mem_forwarder.sv
thread_table.sv
cpu_dispatcher.sv
tb_cpu_dispatcher.sv

// ==== Bender.yml ====
package:
  name: cpu_dispatcher

sources:
  - disp_cfg_pkg.sv
  - disp_msg_pkg.sv
  - thread_cmd_if.sv
  - dispatch_ctl.sv
  - mem_forwarder.sv
  - thread_table.sv
  - cpu_dispatcher.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu_dispatcher.sv
